//--- rtl/stream_defines.svh
/*
 * Width macros shared by the stream packages and the sample routing RTL.
 * Include this header wherever a stream width is needed; the guard makes
 * repeated inclusion harmless.
 */
`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// ADC sample width in bits, two's complement
`define DATA_WIDTH 16

// Routing tag carried beside every beat
`define DEST_WIDTH 8

// Side-band word carried beside every beat
`define USER_WIDTH 16

// Width of the decimation ratio, so ratios run from 0 to 15
`define DECIM_WIDTH 4

`endif

//--- rtl/stream_pkg.sv
/*
 * Types of a single stream beat: the signed ADC sample, its routing tag
 * and its side-band word, plus the saturation limits of the sample.
 * Compile before any RTL that carries a stream.
 */
`default_nettype none

`include "stream_defines.svh"

package stream_pkg;

    // Raw and calibrated samples share this signed type
    typedef logic signed [`DATA_WIDTH-1:0] sample_t;
    typedef logic [`DEST_WIDTH-1:0] dest_t;
    typedef logic [`USER_WIDTH-1:0] user_t;

    // Largest and smallest values a sample can hold
    localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(`DATA_WIDTH-1){1'b1}}});
    localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(`DATA_WIDTH-1){1'b0}}});

endpackage

`default_nettype wire

//--- rtl/control_pkg.sv
/*
 * Types of the static configuration inputs of the sample router: the
 * lane address of the output multiplexer and the decimation ratio.
 */
`default_nettype none

`include "stream_defines.svh"

package control_pkg;

    // Address 0 picks lane 1 and address 3 picks lane 4
    typedef logic [1:0] lane_select_t;

    // Unsigned keep-one-in-N ratio, where 0 and 1 both keep every beat
    typedef logic [`DECIM_WIDTH-1:0] decim_ratio_t;

endpackage

`default_nettype wire

//--- rtl/offset_calibrator.sv
/*
 * Offset calibration for ADC lanes 1 and 2. Each lane subtracts its static
 * offset, clamps the result to the sample range and registers the beat.
 * Ready passes straight back upstream without a register.
 */
`timescale 1ns/10ps
`default_nettype none

`include "stream_defines.svh"

module offset_calibrator (
    input logic clock,
    input logic reset,
    input stream_pkg::sample_t lane_1_data,
    input stream_pkg::dest_t lane_1_dest,
    input stream_pkg::user_t lane_1_user,
    input logic lane_1_tlast,
    input logic lane_1_valid,
    output logic lane_1_ready,
    input stream_pkg::sample_t lane_2_data,
    input stream_pkg::dest_t lane_2_dest,
    input stream_pkg::user_t lane_2_user,
    input logic lane_2_tlast,
    input logic lane_2_valid,
    output logic lane_2_ready,
    input stream_pkg::sample_t offset_1,
    input stream_pkg::sample_t offset_2,
    output stream_pkg::sample_t cal_1_data,
    output stream_pkg::dest_t cal_1_dest,
    output stream_pkg::user_t cal_1_user,
    output logic cal_1_tlast,
    output logic cal_1_valid,
    input logic cal_1_ready,
    output stream_pkg::sample_t cal_2_data,
    output stream_pkg::dest_t cal_2_dest,
    output stream_pkg::user_t cal_2_user,
    output logic cal_2_tlast,
    output logic cal_2_valid,
    input logic cal_2_ready
);
    import stream_pkg::*;

    // One extra bit keeps the difference of two full-range samples exact
    logic signed [`DATA_WIDTH:0] diff_1;
    logic signed [`DATA_WIDTH:0] diff_2;

    // Clamp a widened difference back into the sample range
    function automatic sample_t saturate(input logic signed [`DATA_WIDTH:0] value);
        if (value > SAMPLE_MAX) begin
            return SAMPLE_MAX;
        end else if (value < SAMPLE_MIN) begin
            return SAMPLE_MIN;
        end
        return sample_t'(value);
    endfunction

    // Both operands are signed, so they sign extend to the wider result
    assign diff_1 = lane_1_data - offset_1;
    assign diff_2 = lane_2_data - offset_2;

    // Back-pressure is not buffered here
    assign lane_1_ready = cal_1_ready;
    assign lane_2_ready = cal_2_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            cal_1_valid <= 1'b0;
            cal_2_valid <= 1'b0;
        end else begin
            cal_1_valid <= lane_1_valid;
            cal_2_valid <= lane_2_valid;
        end
    end

    // Payload follows valid through the same register stage
    always_ff @(posedge clock) begin
        cal_1_data <= saturate(diff_1);
        cal_1_dest <= lane_1_dest;
        cal_1_user <= lane_1_user;
        cal_1_tlast <= lane_1_tlast;
        cal_2_data <= saturate(diff_2);
        cal_2_dest <= lane_2_dest;
        cal_2_user <= lane_2_user;
        cal_2_tlast <= lane_2_tlast;
    end

    // Downstream must see no beat in the first cycle out of reset
    a_valid_low_after_reset: assert property (
        @(posedge clock) !reset |=> !cal_1_valid && !cal_2_valid
    );

endmodule

`default_nettype wire

//--- rtl/sample_decimator.sv
/*
 * Keep-one-in-N decimation for ADC lanes 3 and 4. Each lane counts its
 * valid beats and forwards only the beat seen while its counter is zero.
 * Outputs are registered and ready passes straight back upstream.
 */
`timescale 1ns/10ps
`default_nettype none

module sample_decimator (
    input logic clock,
    input logic reset,
    input stream_pkg::sample_t lane_3_data,
    input stream_pkg::dest_t lane_3_dest,
    input stream_pkg::user_t lane_3_user,
    input logic lane_3_tlast,
    input logic lane_3_valid,
    output logic lane_3_ready,
    input stream_pkg::sample_t lane_4_data,
    input stream_pkg::dest_t lane_4_dest,
    input stream_pkg::user_t lane_4_user,
    input logic lane_4_tlast,
    input logic lane_4_valid,
    output logic lane_4_ready,
    input control_pkg::decim_ratio_t decim_ratio_3,
    input control_pkg::decim_ratio_t decim_ratio_4,
    output stream_pkg::sample_t dec_3_data,
    output stream_pkg::dest_t dec_3_dest,
    output stream_pkg::user_t dec_3_user,
    output logic dec_3_tlast,
    output logic dec_3_valid,
    input logic dec_3_ready,
    output stream_pkg::sample_t dec_4_data,
    output stream_pkg::dest_t dec_4_dest,
    output stream_pkg::user_t dec_4_user,
    output logic dec_4_tlast,
    output logic dec_4_valid,
    input logic dec_4_ready
);
    import control_pkg::*;

    // Position of the next valid beat within the current group of N
    decim_ratio_t count_3;
    decim_ratio_t count_4;
    logic wrap_3;
    logic wrap_4;

    // A ratio of 0 or 1 wraps on every beat, so every beat is kept
    assign wrap_3 = (decim_ratio_3 <= 1) || (count_3 == decim_ratio_3 - 1'b1);
    assign wrap_4 = (decim_ratio_4 <= 1) || (count_4 == decim_ratio_4 - 1'b1);

    assign lane_3_ready = dec_3_ready;
    assign lane_4_ready = dec_4_ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count_3 <= '0;
            count_4 <= '0;
            dec_3_valid <= 1'b0;
            dec_4_valid <= 1'b0;
        end else begin
            // Dropped beats leave the output valid low for that cycle
            dec_3_valid <= lane_3_valid && (count_3 == '0);
            dec_4_valid <= lane_4_valid && (count_4 == '0);
            if (lane_3_valid) begin
                count_3 <= wrap_3 ? '0 : count_3 + 1'b1;
            end
            if (lane_4_valid) begin
                count_4 <= wrap_4 ? '0 : count_4 + 1'b1;
            end
        end
    end

    // Payload is registered every cycle and only matters when valid is high
    always_ff @(posedge clock) begin
        dec_3_data <= lane_3_data;
        dec_3_dest <= lane_3_dest;
        dec_3_user <= lane_3_user;
        dec_3_tlast <= lane_3_tlast;
        dec_4_data <= lane_4_data;
        dec_4_dest <= lane_4_dest;
        dec_4_user <= lane_4_user;
        dec_4_tlast <= lane_4_tlast;
    end

    // An output beat must come from an input beat one cycle earlier
    a_valid_follows_input: assert property (
        @(posedge clock) disable iff (!reset)
        ($rose(dec_3_valid) |-> $past(lane_3_valid)) and
        ($rose(dec_4_valid) |-> $past(lane_4_valid))
    );

endmodule

`default_nettype wire

//--- rtl/stream_mux_4.sv
/*
 * Registered four-way stream multiplexer. The lane picked by address is
 * copied to stream_out one cycle later, and that lane alone gets a
 * registered copy of stream_out_ready; the other readies are held low.
 */
`timescale 1ns/10ps
`default_nettype none

module stream_mux_4 (
    input logic clock,
    input logic reset,
    input control_pkg::lane_select_t address,
    input stream_pkg::sample_t stream_in_1_data,
    input stream_pkg::dest_t stream_in_1_dest,
    input stream_pkg::user_t stream_in_1_user,
    input logic stream_in_1_tlast,
    input logic stream_in_1_valid,
    output logic stream_in_1_ready,
    input stream_pkg::sample_t stream_in_2_data,
    input stream_pkg::dest_t stream_in_2_dest,
    input stream_pkg::user_t stream_in_2_user,
    input logic stream_in_2_tlast,
    input logic stream_in_2_valid,
    output logic stream_in_2_ready,
    input stream_pkg::sample_t stream_in_3_data,
    input stream_pkg::dest_t stream_in_3_dest,
    input stream_pkg::user_t stream_in_3_user,
    input logic stream_in_3_tlast,
    input logic stream_in_3_valid,
    output logic stream_in_3_ready,
    input stream_pkg::sample_t stream_in_4_data,
    input stream_pkg::dest_t stream_in_4_dest,
    input stream_pkg::user_t stream_in_4_user,
    input logic stream_in_4_tlast,
    input logic stream_in_4_valid,
    output logic stream_in_4_ready,
    output stream_pkg::sample_t stream_out_data,
    output stream_pkg::dest_t stream_out_dest,
    output stream_pkg::user_t stream_out_user,
    output logic stream_out_tlast,
    output logic stream_out_valid,
    input logic stream_out_ready
);

    // Control state: valid and the upstream readies
    // The ready copy lags stream_out_ready by one cycle, so a beat can be
    // lost or repeated under back-pressure
    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_out_valid <= 1'b0;
            stream_in_1_ready <= 1'b0;
            stream_in_2_ready <= 1'b0;
            stream_in_3_ready <= 1'b0;
            stream_in_4_ready <= 1'b0;
        end else begin
            stream_in_1_ready <= 1'b0;
            stream_in_2_ready <= 1'b0;
            stream_in_3_ready <= 1'b0;
            stream_in_4_ready <= 1'b0;
            case (address)
                2'd0: begin
                    stream_out_valid <= stream_in_1_valid;
                    stream_in_1_ready <= stream_out_ready;
                end
                2'd1: begin
                    stream_out_valid <= stream_in_2_valid;
                    stream_in_2_ready <= stream_out_ready;
                end
                2'd2: begin
                    stream_out_valid <= stream_in_3_valid;
                    stream_in_3_ready <= stream_out_ready;
                end
                default: begin
                    stream_out_valid <= stream_in_4_valid;
                    stream_in_4_ready <= stream_out_ready;
                end
            endcase
        end
    end

    // Payload of the selected lane, same register stage as valid
    always_ff @(posedge clock) begin
        case (address)
            2'd0: begin
                stream_out_data <= stream_in_1_data;
                stream_out_dest <= stream_in_1_dest;
                stream_out_user <= stream_in_1_user;
                stream_out_tlast <= stream_in_1_tlast;
            end
            2'd1: begin
                stream_out_data <= stream_in_2_data;
                stream_out_dest <= stream_in_2_dest;
                stream_out_user <= stream_in_2_user;
                stream_out_tlast <= stream_in_2_tlast;
            end
            2'd2: begin
                stream_out_data <= stream_in_3_data;
                stream_out_dest <= stream_in_3_dest;
                stream_out_user <= stream_in_3_user;
                stream_out_tlast <= stream_in_3_tlast;
            end
            default: begin
                stream_out_data <= stream_in_4_data;
                stream_out_dest <= stream_in_4_dest;
                stream_out_user <= stream_in_4_user;
                stream_out_tlast <= stream_in_4_tlast;
            end
        endcase
    end

    // Upstream never sees more than one lane granted at a time
    a_single_ready: assert property (
        @(posedge clock)
        $onehot0({stream_in_1_ready, stream_in_2_ready, stream_in_3_ready, stream_in_4_ready})
    );

endmodule

`default_nettype wire

//--- rtl/adc_stream_router.sv
/*
 * Top level of the ADC sample routing front end. Lanes 1 and 2 are offset
 * calibrated, lanes 3 and 4 are decimated, and the four results meet in a
 * registered multiplexer. A sample reaches stream_out two cycles later.
 */
`timescale 1ns/10ps
`default_nettype none

module adc_stream_router (
    input logic clock,
    input logic reset,
    input stream_pkg::sample_t lane_1_data,
    input stream_pkg::dest_t lane_1_dest,
    input stream_pkg::user_t lane_1_user,
    input logic lane_1_tlast,
    input logic lane_1_valid,
    output logic lane_1_ready,
    input stream_pkg::sample_t lane_2_data,
    input stream_pkg::dest_t lane_2_dest,
    input stream_pkg::user_t lane_2_user,
    input logic lane_2_tlast,
    input logic lane_2_valid,
    output logic lane_2_ready,
    input stream_pkg::sample_t lane_3_data,
    input stream_pkg::dest_t lane_3_dest,
    input stream_pkg::user_t lane_3_user,
    input logic lane_3_tlast,
    input logic lane_3_valid,
    output logic lane_3_ready,
    input stream_pkg::sample_t lane_4_data,
    input stream_pkg::dest_t lane_4_dest,
    input stream_pkg::user_t lane_4_user,
    input logic lane_4_tlast,
    input logic lane_4_valid,
    output logic lane_4_ready,
    input stream_pkg::sample_t offset_1,
    input stream_pkg::sample_t offset_2,
    input control_pkg::decim_ratio_t decim_ratio_3,
    input control_pkg::decim_ratio_t decim_ratio_4,
    input control_pkg::lane_select_t address,
    output stream_pkg::sample_t stream_out_data,
    output stream_pkg::dest_t stream_out_dest,
    output stream_pkg::user_t stream_out_user,
    output logic stream_out_tlast,
    output logic stream_out_valid,
    input logic stream_out_ready
);
    import stream_pkg::*;

    // Calibrated lanes feeding multiplexer inputs 1 and 2
    sample_t cal_1_data, cal_2_data;
    dest_t cal_1_dest, cal_2_dest;
    user_t cal_1_user, cal_2_user;
    logic cal_1_tlast, cal_2_tlast;
    logic cal_1_valid, cal_2_valid;
    logic cal_1_ready, cal_2_ready;

    // Decimated lanes feeding multiplexer inputs 3 and 4
    sample_t dec_3_data, dec_4_data;
    dest_t dec_3_dest, dec_4_dest;
    user_t dec_3_user, dec_4_user;
    logic dec_3_tlast, dec_4_tlast;
    logic dec_3_valid, dec_4_valid;
    logic dec_3_ready, dec_4_ready;

    offset_calibrator i_offset_calibrator (
        .clock, .reset,
        .lane_1_data, .lane_1_dest, .lane_1_user, .lane_1_tlast, .lane_1_valid, .lane_1_ready,
        .lane_2_data, .lane_2_dest, .lane_2_user, .lane_2_tlast, .lane_2_valid, .lane_2_ready,
        .offset_1, .offset_2,
        .cal_1_data, .cal_1_dest, .cal_1_user, .cal_1_tlast, .cal_1_valid, .cal_1_ready,
        .cal_2_data, .cal_2_dest, .cal_2_user, .cal_2_tlast, .cal_2_valid, .cal_2_ready
    );

    sample_decimator i_sample_decimator (
        .clock, .reset,
        .lane_3_data, .lane_3_dest, .lane_3_user, .lane_3_tlast, .lane_3_valid, .lane_3_ready,
        .lane_4_data, .lane_4_dest, .lane_4_user, .lane_4_tlast, .lane_4_valid, .lane_4_ready,
        .decim_ratio_3, .decim_ratio_4,
        .dec_3_data, .dec_3_dest, .dec_3_user, .dec_3_tlast, .dec_3_valid, .dec_3_ready,
        .dec_4_data, .dec_4_dest, .dec_4_user, .dec_4_tlast, .dec_4_valid, .dec_4_ready
    );

    // The selected lane's ready is registered once, in the multiplexer
    stream_mux_4 i_stream_mux_4 (
        .clock, .reset, .address,
        .stream_in_1_data(cal_1_data), .stream_in_1_dest(cal_1_dest),
        .stream_in_1_user(cal_1_user), .stream_in_1_tlast(cal_1_tlast),
        .stream_in_1_valid(cal_1_valid), .stream_in_1_ready(cal_1_ready),
        .stream_in_2_data(cal_2_data), .stream_in_2_dest(cal_2_dest),
        .stream_in_2_user(cal_2_user), .stream_in_2_tlast(cal_2_tlast),
        .stream_in_2_valid(cal_2_valid), .stream_in_2_ready(cal_2_ready),
        .stream_in_3_data(dec_3_data), .stream_in_3_dest(dec_3_dest),
        .stream_in_3_user(dec_3_user), .stream_in_3_tlast(dec_3_tlast),
        .stream_in_3_valid(dec_3_valid), .stream_in_3_ready(dec_3_ready),
        .stream_in_4_data(dec_4_data), .stream_in_4_dest(dec_4_dest),
        .stream_in_4_user(dec_4_user), .stream_in_4_tlast(dec_4_tlast),
        .stream_in_4_valid(dec_4_valid), .stream_in_4_ready(dec_4_ready),
        .stream_out_data, .stream_out_dest, .stream_out_user,
        .stream_out_tlast, .stream_out_valid, .stream_out_ready
    );

endmodule

`default_nettype wire

//--- testbench/adc_stream_router_tb.sv
/*
 * Self-checking testbench of the ADC sample router. A table of tests is
 * applied back to back, so address changes land mid-stream, and a
 * two-stage reference model predicts stream_out and every lane ready.
 */
`timescale 1ns/10ps
`default_nettype none

module adc_stream_router_tb;
    import stream_pkg::*;
    import control_pkg::*;

    localparam int NUM_TESTS = 12;
    localparam int DRAIN_CYCLES = 3;

    logic clock;
    logic reset;
    sample_t lane_data [4];
    dest_t lane_dest [4];
    user_t lane_user [4];
    logic [3:0] lane_tlast;
    logic [3:0] lane_valid;
    wire [3:0] lane_ready;
    sample_t offset_1;
    sample_t offset_2;
    decim_ratio_t decim_ratio_3;
    decim_ratio_t decim_ratio_4;
    lane_select_t address;
    sample_t stream_out_data;
    dest_t stream_out_dest;
    user_t stream_out_user;
    logic stream_out_tlast;
    logic stream_out_valid;
    logic stream_out_ready;

    // Test table, one entry per row in every array
    string test_name [NUM_TESTS];
    int test_address [NUM_TESTS];
    int test_offset_1 [NUM_TESTS];
    int test_offset_2 [NUM_TESTS];
    int test_ratio_3 [NUM_TESTS];
    int test_ratio_4 [NUM_TESTS];
    int test_beats [NUM_TESTS];
    int test_start [NUM_TESTS][4];
    bit test_toggle [NUM_TESTS];

    // Reference model: first register stage per lane, then the output stage
    sample_t stage_data [4];
    dest_t stage_dest [4];
    user_t stage_user [4];
    logic [3:0] stage_tlast;
    logic [3:0] stage_valid;
    decim_ratio_t dec_count [2];
    sample_t exp_data;
    dest_t exp_dest;
    user_t exp_user;
    logic exp_tlast;
    logic exp_valid;
    logic [3:0] exp_ready;

    logic [31:0] lfsr_state;
    string current_test;
    int error_count;
    int check_count;
    int cycle_count;
    int cycle_limit;

    adc_stream_router i_adc_stream_router (
        .clock, .reset,
        .lane_1_data(lane_data[0]), .lane_1_dest(lane_dest[0]), .lane_1_user(lane_user[0]),
        .lane_1_tlast(lane_tlast[0]), .lane_1_valid(lane_valid[0]), .lane_1_ready(lane_ready[0]),
        .lane_2_data(lane_data[1]), .lane_2_dest(lane_dest[1]), .lane_2_user(lane_user[1]),
        .lane_2_tlast(lane_tlast[1]), .lane_2_valid(lane_valid[1]), .lane_2_ready(lane_ready[1]),
        .lane_3_data(lane_data[2]), .lane_3_dest(lane_dest[2]), .lane_3_user(lane_user[2]),
        .lane_3_tlast(lane_tlast[2]), .lane_3_valid(lane_valid[2]), .lane_3_ready(lane_ready[2]),
        .lane_4_data(lane_data[3]), .lane_4_dest(lane_dest[3]), .lane_4_user(lane_user[3]),
        .lane_4_tlast(lane_tlast[3]), .lane_4_valid(lane_valid[3]), .lane_4_ready(lane_ready[3]),
        .offset_1, .offset_2, .decim_ratio_3, .decim_ratio_4, .address,
        .stream_out_data, .stream_out_dest, .stream_out_user,
        .stream_out_tlast, .stream_out_valid, .stream_out_ready
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Ends a run that stops making progress
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run passed %0d clock cycles without finishing", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic lfsr_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], lfsr_bit()};
        end
        return value;
    endfunction

    // Sample minus offset, clamped to the 16-bit signed range
    function automatic sample_t calibrate(input sample_t sample, input sample_t offset);
        int diff;
        diff = int'(sample) - int'(offset);
        if (diff > 32767) begin
            diff = 32767;
        end else if (diff < -32768) begin
            diff = -32768;
        end
        return sample_t'(diff);
    endfunction

    // Beat counter runs 0 to ratio-1; ratios 0 and 1 keep it at zero
    function automatic decim_ratio_t next_count(input decim_ratio_t count,
                                                input decim_ratio_t ratio);
        if (int'(ratio) < 2 || int'(count) == int'(ratio) - 1) begin
            return '0;
        end
        return decim_ratio_t'(int'(count) + 1);
    endfunction

    task automatic set_row(input int row, input string name, input int addr, input int off_1,
                           input int off_2, input int ratio_3, input int ratio_4,
                           input int beats, input int s1, input int s2, input int s3,
                           input int s4, input bit toggle);
        test_name[row] = name;
        test_address[row] = addr;
        test_offset_1[row] = off_1;
        test_offset_2[row] = off_2;
        test_ratio_3[row] = ratio_3;
        test_ratio_4[row] = ratio_4;
        test_beats[row] = beats;
        test_start[row] = '{s1, s2, s3, s4};
        test_toggle[row] = toggle;
    endtask

    task automatic drive_beat(input int row, input int beat);
        for (int k = 0; k < 4; k++) begin
            lane_data[k] = sample_t'(test_start[row][k] + int'(random_byte()));
            lane_dest[k] = dest_t'(16 * (k + 1) + beat);
            // The lane number in the top nibble tells the side-band words apart
            lane_user[k] = user_t'(4096 * k + 256 * row + beat);
            // Lane k closes its packets every k+2 beats and so frames unlike its neighbours
            lane_tlast[k] = (beat % (k + 2) == k + 1);
        end
        lane_valid = 4'b1111;
        address = lane_select_t'(test_address[row]);
        offset_1 = sample_t'(test_offset_1[row]);
        offset_2 = sample_t'(test_offset_2[row]);
        decim_ratio_3 = decim_ratio_t'(test_ratio_3[row]);
        decim_ratio_4 = decim_ratio_t'(test_ratio_4[row]);
        // Steering rows drop ready on every even beat
        stream_out_ready = test_toggle[row] ? beat[0] : 1'b1;
    endtask

    // Output stage takes the old first stage, then the first stage takes the inputs
    task automatic predict();
        int sel;
        sel = int'(address);
        exp_valid = stage_valid[sel];
        exp_data = stage_data[sel];
        exp_dest = stage_dest[sel];
        exp_user = stage_user[sel];
        exp_tlast = stage_tlast[sel];
        exp_ready = '0;
        exp_ready[sel] = stream_out_ready;
        for (int k = 0; k < 4; k++) begin
            stage_dest[k] = lane_dest[k];
            stage_user[k] = lane_user[k];
            stage_tlast[k] = lane_tlast[k];
        end
        stage_data[0] = calibrate(lane_data[0], offset_1);
        stage_data[1] = calibrate(lane_data[1], offset_2);
        stage_data[2] = lane_data[2];
        stage_data[3] = lane_data[3];
        stage_valid[1:0] = lane_valid[1:0];
        // Decimated lanes forward only the beat seen at count zero
        stage_valid[2] = lane_valid[2] && (dec_count[0] == '0);
        stage_valid[3] = lane_valid[3] && (dec_count[1] == '0);
        if (lane_valid[2]) begin
            dec_count[0] = next_count(dec_count[0], decim_ratio_3);
        end
        if (lane_valid[3]) begin
            dec_count[1] = next_count(dec_count[1], decim_ratio_4);
        end
    endtask

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s %s: expected %h, actual %h",
                     current_test, field, expected, actual);
        end
    endtask

    task automatic check_outputs();
        compare("stream_out_valid", exp_valid, stream_out_valid);
        // Payload only carries meaning on a valid beat
        if (exp_valid) begin
            compare("stream_out_data", exp_data, stream_out_data);
            compare("stream_out_dest", exp_dest, stream_out_dest);
            compare("stream_out_user", exp_user, stream_out_user);
            compare("stream_out_tlast", exp_tlast, stream_out_tlast);
        end
        compare("lane_ready", exp_ready, lane_ready);
    endtask

    // Predict, let one edge pass and compare once the registers have settled
    task automatic step();
        predict();
        @(posedge clock);
        #2;
        check_outputs();
    endtask

    initial begin
        lfsr_state = 32'hcc4e_3fed;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        set_row(0, "cal_lane_1", 0, 100, -50, 1, 1, 8, 1000, -2000, 300, 400, 0);
        set_row(1, "cal_lane_2", 1, 100, -50, 1, 1, 8, 1000, -2000, 300, 400, 0);
        set_row(2, "sat_max_lane_1", 0, -10000, 10000, 1, 1, 6, 30000, -30000, 0, 0, 0);
        set_row(3, "sat_min_lane_2", 1, -10000, 10000, 1, 1, 6, 30000, -30000, 0, 0, 0);
        set_row(4, "decim_lane_3_ratio_1", 2, 0, 0, 1, 3, 8, 0, 0, -500, 700, 0);
        set_row(5, "decim_lane_3_ratio_3", 2, 0, 0, 3, 3, 12, 0, 0, -500, 700, 0);
        set_row(6, "decim_lane_4_ratio_3", 3, 0, 0, 3, 3, 12, 0, 0, -500, 700, 0);
        set_row(7, "decim_lane_4_ratio_7", 3, 0, 0, 3, 7, 21, 0, 0, -500, 700, 0);
        set_row(8, "switch_to_lane_1", 0, 25, 0, 3, 7, 4, 2000, 0, -500, 700, 0);
        set_row(9, "switch_to_lane_3", 2, 25, 0, 7, 7, 14, 2000, 0, -500, 700, 0);
        set_row(10, "ready_steer_lane_2", 1, 0, 300, 1, 1, 8, 0, 4000, 0, 0, 1);
        set_row(11, "ready_steer_lane_4", 3, 0, 300, 1, 1, 8, 0, 4000, 0, -900, 1);
        // Reset, every table beat and the drain, plus some margin
        cycle_limit = 5 + DRAIN_CYCLES + 20;
        for (int row = 0; row < NUM_TESTS; row++) begin
            cycle_limit += test_beats[row];
        end

        reset = 1'b0;
        address = '0;
        offset_1 = '0;
        offset_2 = '0;
        decim_ratio_3 = '0;
        decim_ratio_4 = '0;
        stream_out_ready = 1'b1;
        for (int k = 0; k < 4; k++) begin
            lane_data[k] = '0;
            lane_dest[k] = '0;
            lane_user[k] = '0;
            stage_data[k] = '0;
            stage_dest[k] = '0;
            stage_user[k] = '0;
        end
        lane_tlast = '0;
        lane_valid = '1;
        stage_tlast = '0;
        stage_valid = '0;
        dec_count = '{2{'0}};
        exp_valid = 1'b0;
        exp_ready = '0;

        // Lane valids and ready are high throughout reset, yet valid and all readies stay low
        repeat (5) @(posedge clock);
        #2;
        current_test = "reset";
        check_outputs();
        reset = 1'b1;

        for (int row = 0; row < NUM_TESTS; row++) begin
            current_test = test_name[row];
            for (int beat = 0; beat < test_beats[row]; beat++) begin
                drive_beat(row, beat);
                step();
            end
        end

        // Flush the last beats out of both register stages
        current_test = "drain";
        lane_valid = '0;
        lane_tlast = '0;
        stream_out_ready = 1'b1;
        repeat (DRAIN_CYCLES) step();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/control_pkg.sv
rtl/offset_calibrator.sv
rtl/sample_decimator.sv
rtl/stream_mux_4.sv
rtl/adc_stream_router.sv
testbench/adc_stream_router_tb.sv
